/* design/rename_config.svh */
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// architectural registers
`define RENAME_REG_NUM 32

// rename registers, power of two so the pointers wrap on their own
`define RENAME_RRF_NUM 16

// register value width
`define RENAME_DATA_LEN 32

`endif

/* design/rename_pkg.sv */
`default_nettype none

`include "rename_config.svh"

package rename_pkg;

	// architectural register number
	typedef logic [$clog2(`RENAME_REG_NUM)-1:0] reg_num_t;

	// rename register tag
	typedef logic [$clog2(`RENAME_RRF_NUM)-1:0] rrftag_t;

	// rrf occupancy, 0 up to RENAME_RRF_NUM
	typedef logic [$clog2(`RENAME_RRF_NUM+1)-1:0] rrf_count_t;

	typedef logic [`RENAME_DATA_LEN-1:0] data_t;

endpackage

`default_nettype wire

/* design/reg_ram_2r1w.sv */
`default_nettype none

module reg_ram_2r1w
	import rename_pkg::*;
#(
	parameter int DEPTH = 32
) (
	input  wire                     clk_i,
	input  wire [$clog2(DEPTH)-1:0] raddr1_i,
	input  wire [$clog2(DEPTH)-1:0] raddr2_i,
	output data_t                   rdata1_o,
	output data_t                   rdata2_o,
	input  wire                     we_i,
	input  wire [$clog2(DEPTH)-1:0] waddr_i,
	input  data_t                   wdata_i
);

	data_t mem [DEPTH];

	// reads are combinational, a write shows up next cycle
	assign rdata1_o = mem[raddr1_i];
	assign rdata2_o = mem[raddr2_i];

	always_ff @(posedge clk_i) begin
		if (we_i) begin
			mem[waddr_i] <= wdata_i;
		end
	end

endmodule

`default_nettype wire

/* design/rename_table.sv */
`default_nettype none

`include "rename_config.svh"

module rename_table
	import rename_pkg::*;
(
	input  wire      clk_i,
	input  wire      reset_i,

	input  reg_num_t rs1_i,
	input  reg_num_t rs2_i,
	output logic     rs1_busy_o,
	output logic     rs2_busy_o,
	output rrftag_t  rs1_rrftag_o,
	output rrftag_t  rs2_rrftag_o,

	input  wire      set_en_i,
	input  reg_num_t set_num_i,
	input  rrftag_t  set_rrftag_i,

	input  wire      commit_en_i,
	input  reg_num_t commit_num_i,
	input  rrftag_t  commit_rrftag_i
);

	logic [`RENAME_REG_NUM-1:0] busy_q;
	rrftag_t                    tag_q [`RENAME_REG_NUM];
	logic                       commit_match;

	assign rs1_busy_o   = busy_q[rs1_i];
	assign rs2_busy_o   = busy_q[rs2_i];
	assign rs1_rrftag_o = tag_q[rs1_i];
	assign rs2_rrftag_o = tag_q[rs2_i];

	// only the newest writer may release the register
	assign commit_match = commit_en_i && (tag_q[commit_num_i] == commit_rrftag_i);

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			busy_q <= '0;
		end else begin
			if (commit_match) begin
				busy_q[commit_num_i] <= 1'b0;
			end
			// a rename in the same cycle wins over the clear
			if (set_en_i) begin
				busy_q[set_num_i] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (set_en_i) begin
			tag_q[set_num_i] <= set_rrftag_i;
		end
	end

	a_no_set_in_reset: assert property (@(posedge clk_i) reset_i |-> !set_en_i);

endmodule

`default_nettype wire

/* design/arch_reg_file.sv */
`default_nettype none

`include "rename_config.svh"

module arch_reg_file
	import rename_pkg::*;
(
	input  wire      clk_i,
	input  wire      reset_i,

	input  reg_num_t rs1_i,
	input  reg_num_t rs2_i,
	output data_t    rs1_data_o,
	output data_t    rs2_data_o,
	output logic     rs1_busy_o,
	output logic     rs2_busy_o,
	output rrftag_t  rs1_rrftag_o,
	output rrftag_t  rs2_rrftag_o,

	input  wire      set_en_i,
	input  reg_num_t set_num_i,
	input  rrftag_t  set_rrftag_i,

	input  wire      commit_en_i,
	input  reg_num_t commit_num_i,
	input  rrftag_t  commit_rrftag_i,
	input  data_t    commit_data_i
);

	// committed values, written from the rrf head
	reg_ram_2r1w #(
		.DEPTH(`RENAME_REG_NUM)
	) u_arf_data (
		.clk_i   (clk_i),
		.raddr1_i(rs1_i),
		.raddr2_i(rs2_i),
		.rdata1_o(rs1_data_o),
		.rdata2_o(rs2_data_o),
		.we_i    (commit_en_i),
		.waddr_i (commit_num_i),
		.wdata_i (commit_data_i)
	);

	rename_table u_rename_table (
		.clk_i          (clk_i),
		.reset_i        (reset_i),
		.rs1_i          (rs1_i),
		.rs2_i          (rs2_i),
		.rs1_busy_o     (rs1_busy_o),
		.rs2_busy_o     (rs2_busy_o),
		.rs1_rrftag_o   (rs1_rrftag_o),
		.rs2_rrftag_o   (rs2_rrftag_o),
		.set_en_i       (set_en_i),
		.set_num_i      (set_num_i),
		.set_rrftag_i   (set_rrftag_i),
		.commit_en_i    (commit_en_i),
		.commit_num_i   (commit_num_i),
		.commit_rrftag_i(commit_rrftag_i)
	);

endmodule

`default_nettype wire

/* design/rename_reg_file.sv */
`default_nettype none

`include "rename_config.svh"

module rename_reg_file
	import rename_pkg::*;
(
	input  wire     clk_i,
	input  wire     reset_i,

	input  wire     alloc_en_i,
	output rrftag_t alloc_rrftag_o,
	output logic    full_o,

	input  rrftag_t rs1_rrftag_i,
	input  rrftag_t rs2_rrftag_i,
	output logic    rs1_valid_o,
	output logic    rs2_valid_o,
	output data_t   rs1_data_o,
	output data_t   rs2_data_o,

	input  wire     wb_en_i,
	input  rrftag_t wb_rrftag_i,
	input  data_t   wb_data_i,

	input  wire     commit_en_i,
	output rrftag_t head_rrftag_o,
	output data_t   head_data_o
);

	rrftag_t                    head_q;
	rrftag_t                    tail_q;
	rrf_count_t                 count_q;
	logic [`RENAME_RRF_NUM-1:0] valid_q;
	data_t                      rrf_data [`RENAME_RRF_NUM];
	rrftag_t                    wb_offset;

	assign alloc_rrftag_o = tail_q;
	assign full_o         = (count_q == rrf_count_t'(`RENAME_RRF_NUM));
	assign head_rrftag_o  = head_q;
	assign head_data_o    = rrf_data[head_q];

	assign rs1_valid_o = valid_q[rs1_rrftag_i];
	assign rs2_valid_o = valid_q[rs2_rrftag_i];
	assign rs1_data_o  = rrf_data[rs1_rrftag_i];
	assign rs2_data_o  = rrf_data[rs2_rrftag_i];

	// distance of the writeback tag from the head, wraps mod 16
	assign wb_offset = wb_rrftag_i - head_q;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			head_q  <= '0;
			tail_q  <= '0;
			count_q <= '0;
			valid_q <= '0;
		end else begin
			if (alloc_en_i) begin
				tail_q <= tail_q + 1'b1;
			end
			if (commit_en_i) begin
				head_q <= head_q + 1'b1;
			end
			// alloc and free together keep the count
			case ({alloc_en_i, commit_en_i})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
			if (wb_en_i) begin
				valid_q[wb_rrftag_i] <= 1'b1;
			end
			if (commit_en_i) begin
				valid_q[head_q] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (wb_en_i) begin
			rrf_data[wb_rrftag_i] <= wb_data_i;
		end
	end

	a_no_alloc_full: assert property (@(posedge clk_i) disable iff (reset_i)
		alloc_en_i |-> !full_o);

	a_commit_ready: assert property (@(posedge clk_i) disable iff (reset_i)
		commit_en_i |-> (count_q != '0) && valid_q[head_q]);

	// writeback only to a tag that sits between head and tail
	a_wb_in_use: assert property (@(posedge clk_i) disable iff (reset_i)
		wb_en_i |-> (rrf_count_t'(wb_offset) < count_q));

endmodule

`default_nettype wire

/* design/operand_select.sv */
`default_nettype none

module operand_select
	import rename_pkg::*;
(
	input  wire     busy_i,
	input  rrftag_t rrftag_i,
	input  data_t   arf_data_i,
	input  wire     rrf_valid_i,
	input  data_t   rrf_data_i,
	output logic    ready_o,
	output data_t   value_o
);

	assign ready_o = !busy_i || rrf_valid_i;

	// committed value, then finished rename value, else the tag to wait on
	always_comb begin
		if (!busy_i) begin
			value_o = arf_data_i;
		end else if (rrf_valid_i) begin
			value_o = rrf_data_i;
		end else begin
			value_o = data_t'(rrftag_i);
		end
	end

endmodule

`default_nettype wire

/* design/rename_core.sv */
`default_nettype none

module rename_core
	import rename_pkg::*;
(
	input  wire      clk_i,
	input  wire      reset_i,

	input  wire      disp_valid_i,
	input  reg_num_t disp_rs1_i,
	input  reg_num_t disp_rs2_i,
	input  wire      disp_dst_en_i,
	input  reg_num_t disp_dst_i,
	output rrftag_t  disp_rrftag_o,
	output logic     rrf_full_o,

	output logic     rs1_ready_o,
	output logic     rs2_ready_o,
	output data_t    rs1_value_o,
	output data_t    rs2_value_o,

	input  wire      wb_valid_i,
	input  rrftag_t  wb_rrftag_i,
	input  data_t    wb_data_i,

	input  wire      commit_valid_i,
	input  reg_num_t commit_dst_i
);

	wire     rename_en;
	wire     rs1_busy;
	wire     rs2_busy;
	rrftag_t rs1_rrftag;
	rrftag_t rs2_rrftag;
	data_t   rs1_arf_data;
	data_t   rs2_arf_data;
	wire     rs1_rrf_valid;
	wire     rs2_rrf_valid;
	data_t   rs1_rrf_data;
	data_t   rs2_rrf_data;
	rrftag_t head_rrftag;
	data_t   head_data;

	assign rename_en = disp_valid_i & disp_dst_en_i;

	arch_reg_file u_arf (
		.clk_i          (clk_i),
		.reset_i        (reset_i),
		.rs1_i          (disp_rs1_i),
		.rs2_i          (disp_rs2_i),
		.rs1_data_o     (rs1_arf_data),
		.rs2_data_o     (rs2_arf_data),
		.rs1_busy_o     (rs1_busy),
		.rs2_busy_o     (rs2_busy),
		.rs1_rrftag_o   (rs1_rrftag),
		.rs2_rrftag_o   (rs2_rrftag),
		.set_en_i       (rename_en),
		.set_num_i      (disp_dst_i),
		.set_rrftag_i   (disp_rrftag_o),
		.commit_en_i    (commit_valid_i),
		.commit_num_i   (commit_dst_i),
		.commit_rrftag_i(head_rrftag),
		.commit_data_i  (head_data)
	);

	rename_reg_file u_rrf (
		.clk_i         (clk_i),
		.reset_i       (reset_i),
		.alloc_en_i    (rename_en),
		.alloc_rrftag_o(disp_rrftag_o),
		.full_o        (rrf_full_o),
		.rs1_rrftag_i  (rs1_rrftag),
		.rs2_rrftag_i  (rs2_rrftag),
		.rs1_valid_o   (rs1_rrf_valid),
		.rs2_valid_o   (rs2_rrf_valid),
		.rs1_data_o    (rs1_rrf_data),
		.rs2_data_o    (rs2_rrf_data),
		.wb_en_i       (wb_valid_i),
		.wb_rrftag_i   (wb_rrftag_i),
		.wb_data_i     (wb_data_i),
		.commit_en_i   (commit_valid_i),
		.head_rrftag_o (head_rrftag),
		.head_data_o   (head_data)
	);

	operand_select u_sel_rs1 (
		.busy_i     (rs1_busy),
		.rrftag_i   (rs1_rrftag),
		.arf_data_i (rs1_arf_data),
		.rrf_valid_i(rs1_rrf_valid),
		.rrf_data_i (rs1_rrf_data),
		.ready_o    (rs1_ready_o),
		.value_o    (rs1_value_o)
	);

	operand_select u_sel_rs2 (
		.busy_i     (rs2_busy),
		.rrftag_i   (rs2_rrftag),
		.arf_data_i (rs2_arf_data),
		.rrf_valid_i(rs2_rrf_valid),
		.rrf_data_i (rs2_rrf_data),
		.ready_o    (rs2_ready_o),
		.value_o    (rs2_value_o)
	);

endmodule

`default_nettype wire

/* sim/rename_core_tb.sv */
`default_nettype none

module rename_core_tb
	import rename_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	logic     clk_i;
	logic     reset_i;
	logic     disp_valid_i;
	reg_num_t disp_rs1_i;
	reg_num_t disp_rs2_i;
	logic     disp_dst_en_i;
	reg_num_t disp_dst_i;
	rrftag_t  disp_rrftag_o;
	logic     rrf_full_o;
	logic     rs1_ready_o;
	logic     rs2_ready_o;
	data_t    rs1_value_o;
	data_t    rs2_value_o;
	logic     wb_valid_i;
	rrftag_t  wb_rrftag_i;
	data_t    wb_data_i;
	logic     commit_valid_i;
	reg_num_t commit_dst_i;

	// expected outputs of the current row
	logic [1:0] exp_vchk;
	rrftag_t    exp_rrftag;
	logic       exp_full;
	logic       exp_rs1_ready;
	data_t      exp_rs1_value;
	logic       exp_rs2_ready;
	data_t      exp_rs2_value;

	string rows[$];
	int    row_idx;
	int    cycle_count;
	int    limit_cycles;

	rename_core u_dut (
		.clk_i         (clk_i),
		.reset_i       (reset_i),
		.disp_valid_i  (disp_valid_i),
		.disp_rs1_i    (disp_rs1_i),
		.disp_rs2_i    (disp_rs2_i),
		.disp_dst_en_i (disp_dst_en_i),
		.disp_dst_i    (disp_dst_i),
		.disp_rrftag_o (disp_rrftag_o),
		.rrf_full_o    (rrf_full_o),
		.rs1_ready_o   (rs1_ready_o),
		.rs2_ready_o   (rs2_ready_o),
		.rs1_value_o   (rs1_value_o),
		.rs2_value_o   (rs2_value_o),
		.wb_valid_i    (wb_valid_i),
		.wb_rrftag_i   (wb_rrftag_i),
		.wb_data_i     (wb_data_i),
		.commit_valid_i(commit_valid_i),
		.commit_dst_i  (commit_dst_i)
	);

	always #4 clk_i = ~clk_i;

	always @(posedge clk_i) begin
		cycle_count = cycle_count + 1;
		if (limit_cycles > 0 && cycle_count > limit_cycles) begin
			$display("Timeout: run did not end within %0d cycles", limit_cycles);
			$display("tests failed");
			$fatal(1);
		end
	end

	task automatic check_data(input string name, input data_t exp, input data_t act);
		if (act !== exp) begin
			$display("Mismatch %s: expected %h, got %h (row %0d)", name, exp, act, row_idx);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	task automatic check_tag(input string name, input rrftag_t exp, input rrftag_t act);
		if (act !== exp) begin
			$display("Mismatch %s: expected %h, got %h (row %0d)", name, exp, act, row_idx);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Mismatch %s: expected %h, got %h (row %0d)", name, exp, act, row_idx);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	task automatic load_cases();
		int    fd;
		string line;
		fd = $fopen("sim/rename_cases.txt", "r");
		if (fd == 0) begin
			$display("Could not open the case file sim/rename_cases.txt");
			$display("tests failed");
			$fatal(1);
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			// skip comments and blank lines
			if (line.len() > 1 && line[0] != "#") begin
				rows.push_back(line);
			end
		end
		$fclose(fd);
	endtask

	task automatic apply_row(input string line);
		int n;
		n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
			disp_valid_i, disp_rs1_i, disp_rs2_i, disp_dst_en_i, disp_dst_i,
			wb_valid_i, wb_rrftag_i, wb_data_i, commit_valid_i, commit_dst_i,
			exp_vchk, exp_rrftag, exp_full, exp_rs1_ready, exp_rs1_value,
			exp_rs2_ready, exp_rs2_value);
		if (n != 17) begin
			$display("Case row %0d has %0d fields instead of 17", row_idx, n);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	task automatic check_outputs();
		check_tag("disp_rrftag_o", exp_rrftag, disp_rrftag_o);
		check_flag("rrf_full_o", exp_full, rrf_full_o);
		check_flag("rs1_ready_o", exp_rs1_ready, rs1_ready_o);
		check_flag("rs2_ready_o", exp_rs2_ready, rs2_ready_o);
		// committed data is unknown until first written
		if (exp_vchk[0]) begin
			check_data("rs1_value_o", exp_rs1_value, rs1_value_o);
		end
		if (exp_vchk[1]) begin
			check_data("rs2_value_o", exp_rs2_value, rs2_value_o);
		end
	endtask

	initial begin
		clk_i          = 1'b0;
		reset_i        = 1'b1;
		disp_valid_i   = 1'b0;
		disp_rs1_i     = '0;
		disp_rs2_i     = '0;
		disp_dst_en_i  = 1'b0;
		disp_dst_i     = '0;
		wb_valid_i     = 1'b0;
		wb_rrftag_i    = '0;
		wb_data_i      = '0;
		commit_valid_i = 1'b0;
		commit_dst_i   = '0;
		cycle_count    = 0;
		limit_cycles   = 0;
		row_idx        = 0;

		load_cases();
		limit_cycles = rows.size() * 4 + 20;

		repeat (3) @(posedge clk_i);
		#1;
		reset_i = 1'b0;

		// one row per cycle, checked at the falling edge
		for (row_idx = 0; row_idx < rows.size(); row_idx++) begin
			apply_row(rows[row_idx]);
			@(negedge clk_i);
			check_outputs();
			@(posedge clk_i);
			#1;
		end

		disp_valid_i   = 1'b0;
		wb_valid_i     = 1'b0;
		commit_valid_i = 1'b0;
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/rename_cases.txt */
# dv rs1 rs2 den dst wv wtag wdata cv cdst | vchk tag full rdy1 val1 rdy2 val2
# all hex, one row per cycle, vchk bit0/bit1 enable the rs1/rs2 value checks
1 01 02 1 01 0 0 00000000 0 00 0 0 0 1 00000000 1 00000000
1 01 02 1 02 0 0 00000000 0 00 1 1 0 0 00000000 1 00000000
0 01 02 0 00 1 0 11111111 0 00 3 2 0 0 00000000 0 00000001
0 01 02 0 00 1 1 22222222 0 00 3 2 0 1 11111111 0 00000001
0 01 02 0 00 0 0 00000000 1 01 3 2 0 1 11111111 1 22222222
0 01 02 0 00 0 0 00000000 1 02 3 2 0 1 11111111 1 22222222
1 01 02 1 01 0 0 00000000 0 00 3 2 0 1 11111111 1 22222222
1 01 02 1 01 1 2 33333333 0 00 3 3 0 0 00000002 1 22222222
0 01 02 0 00 0 0 00000000 1 01 3 4 0 0 00000003 1 22222222
0 01 02 0 00 1 3 44444444 0 00 3 4 0 0 00000003 1 22222222
0 01 02 0 00 0 0 00000000 1 01 3 4 0 1 44444444 1 22222222
0 01 02 0 00 0 0 00000000 0 00 3 4 0 1 44444444 1 22222222
1 02 01 1 02 0 0 00000000 0 00 3 4 0 1 22222222 1 44444444
0 02 01 0 00 1 4 55555555 0 00 3 5 0 0 00000004 1 44444444
1 02 01 1 02 0 0 00000000 1 02 3 5 0 1 55555555 1 44444444
0 02 01 0 00 0 0 00000000 0 00 3 6 0 0 00000005 1 44444444
1 02 01 1 03 0 0 00000000 0 00 3 6 0 0 00000005 1 44444444
1 02 01 1 04 0 0 00000000 0 00 3 7 0 0 00000005 1 44444444
1 02 01 1 05 0 0 00000000 0 00 3 8 0 0 00000005 1 44444444
1 02 01 1 06 0 0 00000000 0 00 3 9 0 0 00000005 1 44444444
1 02 01 1 07 0 0 00000000 0 00 3 a 0 0 00000005 1 44444444
1 02 01 1 08 0 0 00000000 0 00 3 b 0 0 00000005 1 44444444
1 02 01 1 09 0 0 00000000 0 00 3 c 0 0 00000005 1 44444444
1 02 01 1 0a 0 0 00000000 0 00 3 d 0 0 00000005 1 44444444
1 02 01 1 0b 0 0 00000000 0 00 3 e 0 0 00000005 1 44444444
1 02 01 1 0c 0 0 00000000 0 00 3 f 0 0 00000005 1 44444444
1 02 01 1 0d 0 0 00000000 0 00 3 0 0 0 00000005 1 44444444
1 02 01 1 0e 0 0 00000000 0 00 3 1 0 0 00000005 1 44444444
1 02 01 1 0f 0 0 00000000 0 00 3 2 0 0 00000005 1 44444444
1 02 01 1 10 0 0 00000000 0 00 3 3 0 0 00000005 1 44444444
1 02 01 1 11 0 0 00000000 0 00 3 4 0 0 00000005 1 44444444
0 02 01 0 00 0 0 00000000 0 00 3 5 1 0 00000005 1 44444444
0 02 01 0 00 1 5 66666666 0 00 3 5 1 0 00000005 1 44444444
0 02 01 0 00 0 0 00000000 1 02 3 5 1 1 66666666 1 44444444
1 02 01 1 02 0 0 00000000 0 00 3 5 0 1 66666666 1 44444444
0 02 01 0 00 0 0 00000000 0 00 3 6 1 0 00000005 1 44444444

/* all.f */
+incdir+design
design/rename_pkg.sv
design/reg_ram_2r1w.sv
design/rename_table.sv
design/arch_reg_file.sv
design/rename_reg_file.sv
design/operand_select.sv
design/rename_core.sv
sim/rename_core_tb.sv

/* Bender.yml */
package:
  name: rename_core

sources:
  - include_dirs:
      - design
    files:
      - design/rename_pkg.sv
      - design/reg_ram_2r1w.sv
      - design/rename_table.sv
      - design/arch_reg_file.sv
      - design/rename_reg_file.sv
      - design/operand_select.sv
      - design/rename_core.sv
  - target: test
    files:
      - sim/rename_core_tb.sv
